//--- source/vic_pkg.sv
package vic_pkg;

    // ------------------------------
    // chip selection
    // ------------------------------
    typedef enum logic [1:0] {
        chip_6567r8   = 2'd0,
        chip_6567r56a = 2'd1,
        chip_6569     = 2'd2,
        chip_unused   = 2'd3
    } chip_e;

    localparam int NUM_SPRITES = 8;
    localparam int RASTER_X_W = 10;
    localparam int RASTER_Y_W = 9;

    // ------------------------------
    // dot4x ticks within a phi half cycle
    // ------------------------------
    localparam int TICKS_PER_DOT = 4;
    localparam int TICKS_PER_HALF = 16;
    localparam int TICK_LINE_EVAL = 1;
    localparam int TICK_IRQ_EVAL = 8;
    localparam int TICK_PHASE_END = 15;

    // badline window, last line is exclusive
    localparam logic [RASTER_Y_W-1:0] BADLINE_FIRST_LINE = 9'd48;
    localparam logic [RASTER_Y_W-1:0] BADLINE_LAST_LINE = 9'd248;

    // c-access ba window, cycle 12 through end of cycle 54
    localparam logic [RASTER_X_W-1:0] CHARS_BA_FIRST_X = 10'd96;
    localparam logic [RASTER_X_W-1:0] CHARS_BA_LAST_X = 10'd439;

    // s-access ba window, relative to sprite_raster_x
    localparam int SPRITE_BA_STEP = 16;
    localparam int SPRITE_BA_LEN = 40;
    localparam int SPRITE_LINES = 21;
    localparam int BA_CASCADE = 3;

    // last pixel index of a line
    function automatic logic [RASTER_X_W-1:0] raster_x_max(chip_e chip);
        case (chip)
            chip_6567r8:   return 10'd519;
            chip_6567r56a: return 10'd511;
            default:       return 10'd503;
        endcase
    endfunction

    // last line of a frame
    function automatic logic [RASTER_Y_W-1:0] raster_y_max(chip_e chip);
        case (chip)
            chip_6567r8:   return 9'd262;
            chip_6567r56a: return 9'd261;
            default:       return 9'd311;
        endcase
    endfunction

    // low phase cycle where sprite y compare happens
    function automatic logic [6:0] sprite_dma_check_cycle(chip_e chip);
        case (chip)
            chip_6567r8, chip_6567r56a: return 7'd55;
            default:                    return 7'd54;
        endcase
    endfunction

    // sprite 0 fetch is 8 pixels past the check cycle start, ba drops 3 cycles earlier
    function automatic logic [RASTER_X_W-1:0] sprite_ba_origin(chip_e chip);
        return {sprite_dma_check_cycle(chip), 3'b000} - 10'd16;
    endfunction

endpackage

//--- source/vic_timing.sv
`timescale 1ns/1ps

module vic_timing (
    input  logic                              clk_dot4x,
    input  logic                              rst,
    input  vic_pkg::chip_e                    chip_i,
    output logic                              clk_phi_o,
    output logic [vic_pkg::TICKS_PER_HALF-1:0] phase_tick_o,
    output logic [vic_pkg::RASTER_X_W-1:0]    raster_x_o,
    output logic [vic_pkg::RASTER_Y_W-1:0]    raster_line_o,
    output logic [vic_pkg::RASTER_X_W-1:0]    sprite_raster_x_o
);

    // full phi period pattern, bit 0 is the current phi level
    logic [2*vic_pkg::TICKS_PER_HALF-1:0] phi_gen;
    logic [vic_pkg::TICKS_PER_HALF-1:0]   phase_ring;
    logic                                 dot_end;
    logic [vic_pkg::RASTER_X_W-1:0]       x_max;
    logic [vic_pkg::RASTER_Y_W-1:0]       y_max;
    logic [vic_pkg::RASTER_X_W-1:0]       ba_origin;

    assign x_max = vic_pkg::raster_x_max(chip_i);
    assign y_max = vic_pkg::raster_y_max(chip_i);
    assign ba_origin = vic_pkg::sprite_ba_origin(chip_i);

    // ------------------------------
    // phi and phase rings
    // ------------------------------
    // starts with phi low on the first tick of the low phase
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phi_gen <= {{vic_pkg::TICKS_PER_HALF{1'b1}}, {vic_pkg::TICKS_PER_HALF{1'b0}}};
            phase_ring <= {{(vic_pkg::TICKS_PER_HALF-1){1'b0}}, 1'b1};
        end else begin
            phi_gen <= {phi_gen[0], phi_gen[2*vic_pkg::TICKS_PER_HALF-1:1]};
            phase_ring <= {phase_ring[vic_pkg::TICKS_PER_HALF-2:0],
                           phase_ring[vic_pkg::TICKS_PER_HALF-1]};
        end
    end

    assign clk_phi_o = phi_gen[0];
    assign phase_tick_o = phase_ring;

    // last tick of each pixel
    always_comb begin
        dot_end = 1'b0;
        for (int k = 0; k < vic_pkg::TICKS_PER_HALF; k++) begin
            if (k % vic_pkg::TICKS_PER_DOT == vic_pkg::TICKS_PER_DOT - 1)
                dot_end = dot_end | phase_ring[k];
        end
    end

    // ------------------------------
    // raster position
    // ------------------------------
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_x_o <= '0;
            raster_line_o <= '0;
        end else if (dot_end) begin
            if (raster_x_o == x_max) begin
                raster_x_o <= '0;
                // new line, frame wraps after the last line
                if (raster_line_o == y_max)
                    raster_line_o <= '0;
                else
                    raster_line_o <= raster_line_o + 1'b1;
            end else begin
                raster_x_o <= raster_x_o + 1'b1;
            end
        end
    end

    // x relative to sprite 0 ba fall, wraps at the line length
    assign sprite_raster_x_o = (raster_x_o >= ba_origin) ? raster_x_o - ba_origin
                                                         : raster_x_o + x_max + 1'b1 - ba_origin;

    a_phase_onehot: assert property (@(posedge clk_dot4x) disable iff (rst)
        $onehot(phase_tick_o));

endmodule

//--- source/vic_badline.sv
`timescale 1ns/1ps

module vic_badline (
    input  logic                               clk_dot4x,
    input  logic                               rst,
    input  logic                               clk_phi_i,
    input  logic [vic_pkg::TICKS_PER_HALF-1:0] phase_tick_i,
    input  logic [vic_pkg::RASTER_X_W-1:0]     raster_x_i,
    input  logic [vic_pkg::RASTER_Y_W-1:0]     raster_line_i,
    input  logic                               den_i,
    input  logic [2:0]                         yscroll_i,
    output logic                               ba_chars_o
);

    logic allow_bad_lines;
    logic allow_next;
    logic badline;
    logic line_eval;
    logic in_window;

    assign line_eval = ~clk_phi_i & phase_tick_i[vic_pkg::TICK_LINE_EVAL];

    assign in_window = (raster_line_i >= vic_pkg::BADLINE_FIRST_LINE) &&
                       (raster_line_i < vic_pkg::BADLINE_LAST_LINE);

    // den seen on line 48 arms badlines, line 248 disarms them
    always_comb begin
        allow_next = allow_bad_lines;
        if (den_i && raster_line_i == vic_pkg::BADLINE_FIRST_LINE)
            allow_next = 1'b1;
        if (raster_line_i == vic_pkg::BADLINE_LAST_LINE)
            allow_next = 1'b0;
    end

    // ------------------------------
    // decision once per cycle, low phase
    // ------------------------------
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            allow_bad_lines <= 1'b0;
            badline <= 1'b0;
        end else if (line_eval) begin
            allow_bad_lines <= allow_next;
            badline <= (raster_line_i[2:0] == yscroll_i) && allow_next && in_window;
        end
    end

    // c-accesses need the bus from cycle 12 through 54
    assign ba_chars_o = badline &&
                        (raster_x_i >= vic_pkg::CHARS_BA_FIRST_X) &&
                        (raster_x_i <= vic_pkg::CHARS_BA_LAST_X);

endmodule

//--- source/vic_sprite_dma.sv
`timescale 1ns/1ps

module vic_sprite_dma #(
    parameter int SPRITE_INDEX = 0
) (
    input  logic                               clk_dot4x,
    input  logic                               rst,
    input  vic_pkg::chip_e                     chip_i,
    input  logic                               clk_phi_i,
    input  logic [vic_pkg::TICKS_PER_HALF-1:0] phase_tick_i,
    input  logic [vic_pkg::RASTER_X_W-1:0]     raster_x_i,
    input  logic [vic_pkg::RASTER_Y_W-1:0]     raster_line_i,
    input  logic [vic_pkg::RASTER_X_W-1:0]     sprite_raster_x_i,
    input  logic                               sprite_en_i,
    input  logic [7:0]                         sprite_y_i,
    output logic                               ba_req_o
);

    // this sprite's ba window in sprite_raster_x units
    localparam logic [9:0] BA_START = 10'(SPRITE_INDEX * vic_pkg::SPRITE_BA_STEP);
    localparam logic [9:0] BA_END = 10'(SPRITE_INDEX * vic_pkg::SPRITE_BA_STEP +
                                        vic_pkg::SPRITE_BA_LEN);
    localparam logic [4:0] LAST_COUNT = 5'(vic_pkg::SPRITE_LINES - 1);

    logic       dma_on;
    logic [4:0] line_count;
    logic       check_tick;

    // low phase of the dma check cycle
    assign check_tick = ~clk_phi_i && phase_tick_i[vic_pkg::TICK_LINE_EVAL] &&
                        (raster_x_i[9:3] == vic_pkg::sprite_dma_check_cycle(chip_i));

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            dma_on <= 1'b0;
            line_count <= '0;
        end else if (check_tick) begin
            if (dma_on) begin
                // 21 lines fetched, sprite is done
                if (line_count == LAST_COUNT)
                    dma_on <= 1'b0;
                else
                    line_count <= line_count + 1'b1;
            end else if (sprite_en_i && sprite_y_i == raster_line_i[7:0]) begin
                dma_on <= 1'b1;
                line_count <= '0;
            end
        end
    end

    assign ba_req_o = dma_on && (sprite_raster_x_i >= BA_START) && (sprite_raster_x_i < BA_END);

    a_count_range: assert property (@(posedge clk_dot4x) disable iff (rst)
        line_count <= LAST_COUNT);

endmodule

//--- source/vic_bus_arbiter.sv
`timescale 1ns/1ps

module vic_bus_arbiter (
    input  logic                               clk_dot4x,
    input  logic                               rst,
    input  logic                               clk_phi_i,
    input  logic [vic_pkg::TICKS_PER_HALF-1:0] phase_tick_i,
    input  logic                               ba_chars_i,
    input  logic [vic_pkg::NUM_SPRITES-1:0]    ba_sprite_i,
    output logic                               ba_o,
    output logic                               aec_o
);

    // stage n is low once ba has been low for n+1 phi cycles
    logic [vic_pkg::BA_CASCADE-1:0] ba_cascade;
    logic                           cascade_shift;

    assign cascade_shift = clk_phi_i & phase_tick_i[vic_pkg::TICK_PHASE_END];

    // ------------------------------
    // ba, low when anyone needs the bus
    // ------------------------------
    always_ff @(posedge clk_dot4x) begin
        if (rst)
            ba_o <= 1'b0;
        else
            ba_o <= ~(ba_chars_i | (|ba_sprite_i));
    end

    // shift at the end of each high phase, a high ba releases every stage
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ba_cascade <= '1;
        end else if (cascade_shift) begin
            ba_cascade[0] <= ba_o;
            for (int i = 1; i < vic_pkg::BA_CASCADE; i++)
                ba_cascade[i] <= ba_cascade[i-1] | ba_o;
        end
    end

    // ------------------------------
    // aec, cpu keeps high phases until the cascade runs out
    // ------------------------------
    always_ff @(posedge clk_dot4x) begin
        if (rst)
            aec_o <= 1'b0;
        else
            aec_o <= ba_o ? clk_phi_i : clk_phi_i & ba_cascade[vic_pkg::BA_CASCADE-1];
    end

    a_aec_in_high: assert property (@(posedge clk_dot4x) disable iff (rst)
        aec_o |-> $past(clk_phi_i));

endmodule

//--- source/vic_raster_irq.sv
`timescale 1ns/1ps

module vic_raster_irq (
    input  logic                               clk_dot4x,
    input  logic                               rst,
    input  logic                               clk_phi_i,
    input  logic [vic_pkg::TICKS_PER_HALF-1:0] phase_tick_i,
    input  logic [vic_pkg::RASTER_Y_W-1:0]     raster_line_i,
    input  logic [vic_pkg::RASTER_Y_W-1:0]     raster_irq_line_i,
    input  logic                               irq_en_i,
    input  logic                               irq_clr_i,
    output logic                               irq_o
);

    // source latch, set regardless of the enable
    logic irst;
    // line already raised its interrupt
    logic raster_irq_triggered;
    logic irq_eval;

    assign irq_eval = ~clk_phi_i & phase_tick_i[vic_pkg::TICK_IRQ_EVAL];

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            irst <= 1'b0;
            raster_irq_triggered <= 1'b0;
        end else begin
            if (raster_line_i == raster_irq_line_i) begin
                if (irq_eval && !raster_irq_triggered) begin
                    raster_irq_triggered <= 1'b1;
                    irst <= 1'b1;
                end
            end else begin
                raster_irq_triggered <= 1'b0;
            end
            // clear from the cpu wins over a new match
            if (irq_clr_i)
                irst <= 1'b0;
        end
    end

    // enabling later still fires on a pending latch
    assign irq_o = irst & irq_en_i;

endmodule

//--- source/vic_dma_core.sv
`timescale 1ns/1ps

module vic_dma_core (
    input  logic                                 clk_dot4x,
    input  logic                                 rst,
    input  vic_pkg::chip_e                       chip_i,
    input  logic                                 den_i,
    input  logic [2:0]                           yscroll_i,
    input  logic [vic_pkg::NUM_SPRITES-1:0]      sprite_en_i,
    input  logic [8*vic_pkg::NUM_SPRITES-1:0]    sprite_y_i,
    input  logic [vic_pkg::RASTER_Y_W-1:0]       raster_irq_line_i,
    input  logic                                 irq_en_i,
    input  logic                                 irq_clr_i,
    output logic                                 clk_phi_o,
    output logic [vic_pkg::RASTER_X_W-1:0]       raster_x_o,
    output logic [vic_pkg::RASTER_Y_W-1:0]       raster_line_o,
    output logic                                 ba_o,
    output logic                                 aec_o,
    output logic                                 irq_o
);

    logic [vic_pkg::TICKS_PER_HALF-1:0] phase_tick;
    logic [vic_pkg::RASTER_X_W-1:0]     sprite_raster_x;
    logic                               ba_chars;
    logic [vic_pkg::NUM_SPRITES-1:0]    ba_sprite;

    // ------------------------------
    // timing and raster position
    // ------------------------------
    vic_timing u_timing (
        .clk_dot4x         (clk_dot4x),
        .rst               (rst),
        .chip_i            (chip_i),
        .clk_phi_o         (clk_phi_o),
        .phase_tick_o      (phase_tick),
        .raster_x_o        (raster_x_o),
        .raster_line_o     (raster_line_o),
        .sprite_raster_x_o (sprite_raster_x)
    );

    vic_badline u_badline (
        .clk_dot4x     (clk_dot4x),
        .rst           (rst),
        .clk_phi_i     (clk_phi_o),
        .phase_tick_i  (phase_tick),
        .raster_x_i    (raster_x_o),
        .raster_line_i (raster_line_o),
        .den_i         (den_i),
        .yscroll_i     (yscroll_i),
        .ba_chars_o    (ba_chars)
    );

    // one dma tracker per sprite, y fields packed 8 bits each
    for (genvar i = 0; i < vic_pkg::NUM_SPRITES; i++) begin : g_sprite
        vic_sprite_dma #(
            .SPRITE_INDEX (i)
        ) u_sprite_dma (
            .clk_dot4x         (clk_dot4x),
            .rst               (rst),
            .chip_i            (chip_i),
            .clk_phi_i         (clk_phi_o),
            .phase_tick_i      (phase_tick),
            .raster_x_i        (raster_x_o),
            .raster_line_i     (raster_line_o),
            .sprite_raster_x_i (sprite_raster_x),
            .sprite_en_i       (sprite_en_i[i]),
            .sprite_y_i        (sprite_y_i[8*i +: 8]),
            .ba_req_o          (ba_sprite[i])
        );
    end

    // ------------------------------
    // bus ownership and interrupt
    // ------------------------------
    vic_bus_arbiter u_bus_arbiter (
        .clk_dot4x    (clk_dot4x),
        .rst          (rst),
        .clk_phi_i    (clk_phi_o),
        .phase_tick_i (phase_tick),
        .ba_chars_i   (ba_chars),
        .ba_sprite_i  (ba_sprite),
        .ba_o         (ba_o),
        .aec_o        (aec_o)
    );

    vic_raster_irq u_raster_irq (
        .clk_dot4x         (clk_dot4x),
        .rst               (rst),
        .clk_phi_i         (clk_phi_o),
        .phase_tick_i      (phase_tick),
        .raster_line_i     (raster_line_o),
        .raster_irq_line_i (raster_irq_line_i),
        .irq_en_i          (irq_en_i),
        .irq_clr_i         (irq_clr_i),
        .irq_o             (irq_o)
    );

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 4,
    parameter int RESET_CYCLES = 10
) (
    input  logic rst_req_i,
    output logic clk_o,
    output logic rst_o
);

    int reset_left;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // reset counts down on falling edges, a request restarts it
    initial begin
        rst_o = 1'b1;
        reset_left = RESET_CYCLES;
        @(posedge clk_o);
        forever begin
            @(negedge clk_o);
            if (rst_req_i) begin
                reset_left = RESET_CYCLES;
                rst_o <= 1'b1;
            end else if (reset_left > 1) begin
                reset_left = reset_left - 1;
            end else begin
                rst_o <= 1'b0;
            end
        end
    end

endmodule

//--- bench/tb_vic_dma_core.sv
`timescale 1ns/1ps

module tb_vic_dma_core;

    localparam int CLK_PERIOD_NS = 4;
    localparam int NUM_CHIPS = 4;
    localparam int MARGIN_TICKS = 4096;

    logic           clk_dot4x;
    logic           rst;
    logic           rst_req;
    vic_pkg::chip_e chip;
    logic           den;
    logic [2:0]     yscroll;
    logic [7:0]     sprite_en;
    logic [63:0]    sprite_y;
    logic [8:0]     irq_line;
    logic           irq_en;
    logic           irq_clr;
    logic           clk_phi;
    logic [9:0]     raster_x;
    logic [8:0]     raster_line;
    logic           ba;
    logic           aec;
    logic           irq;

    // ------------------------------
    // reference model state
    // ------------------------------
    logic       m_phi;
    int         m_tick;
    int         m_rx;
    int         m_ry;
    logic       m_allow;
    logic       m_bad;
    logic [7:0] m_dma;
    int         m_cnt [8];
    logic       m_ba;
    logic [2:0] m_casc;
    logic       m_aec;
    logic       m_irst;
    logic       m_trig;

    logic [31:0] rng;
    int          frame_count;
    int          ba_low_ticks;
    int          aec_stall_ticks;
    int          irq_high_ticks;

    tb_clock #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (10)
    ) u_clock (
        .rst_req_i (rst_req),
        .clk_o     (clk_dot4x),
        .rst_o     (rst)
    );

    vic_dma_core UUT (
        .clk_dot4x         (clk_dot4x),
        .rst               (rst),
        .chip_i            (chip),
        .den_i             (den),
        .yscroll_i         (yscroll),
        .sprite_en_i       (sprite_en),
        .sprite_y_i        (sprite_y),
        .raster_irq_line_i (irq_line),
        .irq_en_i          (irq_en),
        .irq_clr_i         (irq_clr),
        .clk_phi_o         (clk_phi),
        .raster_x_o        (raster_x),
        .raster_line_o     (raster_line),
        .ba_o              (ba),
        .aec_o             (aec),
        .irq_o             (irq)
    );

    // run order of the chip types
    function automatic vic_pkg::chip_e chip_at(input int c);
        case (c)
            0:       return vic_pkg::chip_6567r8;
            1:       return vic_pkg::chip_6567r56a;
            2:       return vic_pkg::chip_6569;
            default: return vic_pkg::chip_unused;
        endcase
    endfunction

    // pixels per line
    function automatic int line_pixels(input vic_pkg::chip_e c);
        case (c)
            vic_pkg::chip_6567r8:   return 520;
            vic_pkg::chip_6567r56a: return 512;
            default:                return 504;
        endcase
    endfunction

    function automatic int frame_lines(input vic_pkg::chip_e c);
        case (c)
            vic_pkg::chip_6567r8:   return 263;
            vic_pkg::chip_6567r56a: return 262;
            default:                return 312;
        endcase
    endfunction

    // cycle of the sprite y compare
    function automatic int check_cycle(input vic_pkg::chip_e c);
        if (c == vic_pkg::chip_6567r8 || c == vic_pkg::chip_6567r56a)
            return 55;
        return 54;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ------------------------------
    // one dot4x tick of the model
    // ------------------------------
    task automatic model_step();
        int   n;
        int   len;
        int   srx;
        logic line_eval;
        logic busy;
        logic ba_next;
        logic aec_next;
        logic allow_next;
        len = line_pixels(chip);
        if (rst) begin
            m_phi = 1'b0;
            m_tick = 0;
            m_rx = 0;
            m_ry = 0;
            m_allow = 1'b0;
            m_bad = 1'b0;
            m_dma = '0;
            for (n = 0; n < 8; n++)
                m_cnt[n] = 0;
            m_ba = 1'b0;
            m_casc = 3'b111;
            m_aec = 1'b0;
            m_irst = 1'b0;
            m_trig = 1'b0;
        end else begin
            line_eval = !m_phi && m_tick == 1;
            // sprite 0 ba falls 16 pixels before the check cycle
            srx = (m_rx + len - (check_cycle(chip) * 8 - 16)) % len;
            busy = m_bad && m_rx >= 96 && m_rx <= 439;
            for (n = 0; n < 8; n++)
                if (m_dma[n] && srx >= 16 * n && srx < 16 * n + 40)
                    busy = 1'b1;
            ba_next = !busy;
            aec_next = m_ba ? m_phi : (m_phi && m_casc[2]);
            // cascade steps at the end of the high phase
            if (m_phi && m_tick == 15)
                m_casc = {m_casc[1] | m_ba, m_casc[0] | m_ba, m_ba};
            m_ba = ba_next;
            m_aec = aec_next;
            if (line_eval) begin
                allow_next = m_allow;
                if (den && m_ry == 48)
                    allow_next = 1'b1;
                if (m_ry == 248)
                    allow_next = 1'b0;
                m_allow = allow_next;
                m_bad = (m_ry % 8 == yscroll) && allow_next && m_ry >= 48 && m_ry < 248;
                if (m_rx / 8 == check_cycle(chip)) begin
                    for (n = 0; n < 8; n++) begin
                        if (m_dma[n]) begin
                            if (m_cnt[n] == 20)
                                m_dma[n] = 1'b0;
                            else
                                m_cnt[n] = m_cnt[n] + 1;
                        end else if (sprite_en[n] && sprite_y[8*n +: 8] == m_ry % 256) begin
                            m_dma[n] = 1'b1;
                            m_cnt[n] = 0;
                        end
                    end
                end
            end
            // raster irq fires once per matching line
            if (m_ry == irq_line) begin
                if (!m_phi && m_tick == 8 && !m_trig) begin
                    m_trig = 1'b1;
                    m_irst = 1'b1;
                end
            end else begin
                m_trig = 1'b0;
            end
            if (irq_clr)
                m_irst = 1'b0;
            // raster position moves on the last tick of a pixel
            if (m_tick % 4 == 3) begin
                if (m_rx == len - 1) begin
                    m_rx = 0;
                    m_ry = (m_ry == frame_lines(chip) - 1) ? 0 : m_ry + 1;
                end else begin
                    m_rx = m_rx + 1;
                end
            end
            if (m_tick == 15)
                m_phi = !m_phi;
            m_tick = (m_tick + 1) % 16;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED: %s at %0t expected %0d actual %0d",
                     name, $time, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "output differs from the reference model");
        end
    endtask

    // new register values at each frame start with sprite ys near the top border
    task automatic draw_frame_inputs();
        int          n;
        logic [63:0] ys;
        rng = xorshift32(rng);
        den <= (rng[1:0] != 2'b00);
        rng = xorshift32(rng);
        yscroll <= rng[2:0];
        rng = xorshift32(rng);
        sprite_en <= rng[7:0];
        ys = '0;
        for (n = 0; n < 8; n++) begin
            rng = xorshift32(rng);
            ys[8*n +: 8] = 8'(40 + rng % 21);
        end
        sprite_y <= ys;
        rng = xorshift32(rng);
        irq_line <= 9'(rng % frame_lines(chip));
    endtask

    // ------------------------------
    // model, compare and drive on falling edges
    // ------------------------------
    initial begin
        @(posedge clk_dot4x);
        forever begin
            @(negedge clk_dot4x);
            model_step();
            check_value("clk_phi", m_phi, clk_phi);
            check_value("raster_x", m_rx, raster_x);
            check_value("raster_line", m_ry, raster_line);
            check_value("ba", m_ba, ba);
            check_value("aec", m_aec, aec);
            check_value("irq", m_irst & irq_en, irq);
            if (!ba)
                ba_low_ticks++;
            if (clk_phi && m_tick > 0 && !aec)
                aec_stall_ticks++;
            if (irq)
                irq_high_ticks++;
            if (m_rx == 0 && m_ry == 0 && m_tick == 0) begin
                if (!rst)
                    frame_count++;
                draw_frame_inputs();
            end
            rng = xorshift32(rng);
            irq_clr <= (rng[13:0] == 14'd0);
            if (rng[31:19] == 13'd0)
                irq_en <= !irq_en;
        end
    end

    // ------------------------------
    // two frames for each chip type
    // ------------------------------
    initial begin
        int c;
        int start_frames;
        chip = chip_at(0);
        den = 1'b1;
        yscroll = 3'd3;
        sprite_en = 8'h00;
        sprite_y = '0;
        irq_line = 9'd50;
        irq_en = 1'b1;
        irq_clr = 1'b0;
        rst_req = 1'b0;
        rng = 32'h1764;
        frame_count = 0;
        ba_low_ticks = 0;
        aec_stall_ticks = 0;
        irq_high_ticks = 0;
        for (c = 0; c < NUM_CHIPS; c++) begin
            if (c > 0) begin
                rst_req <= 1'b1;
                @(negedge clk_dot4x);
                rst_req <= 1'b0;
                while (!rst)
                    @(negedge clk_dot4x);
                // chip type only changes under reset
                chip <= chip_at(c);
            end
            start_frames = frame_count;
            wait (frame_count >= start_frames + 2);
            @(negedge clk_dot4x);
        end
        if (ba_low_ticks > 0 && aec_stall_ticks > 0 && irq_high_ticks > 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("stimulus never pulled ba low, stalled aec or raised irq");
            $display("STATUS: FAIL");
            $fatal(1, "stimulus too weak");
        end
    end

    // limit from the frame lengths of every run
    initial begin
        longint limit_ticks;
        int c;
        limit_ticks = 0;
        for (c = 0; c < NUM_CHIPS; c++)
            limit_ticks += 2 * 4 * line_pixels(chip_at(c)) * frame_lines(chip_at(c))
                           + MARGIN_TICKS;
        #(limit_ticks * CLK_PERIOD_NS);
        $display("watchdog expired before all chip runs finished");
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    end

endmodule

//--- tb.f
source/vic_pkg.sv
source/vic_timing.sv
source/vic_badline.sv
source/vic_sprite_dma.sv
source/vic_bus_arbiter.sv
source/vic_raster_irq.sv
source/vic_dma_core.sv
bench/tb_clock.sv
bench/tb_vic_dma_core.sv

//--- Bender.yml
package:
  name: vic_dma_core

sources:
  - source/vic_pkg.sv
  - source/vic_timing.sv
  - source/vic_badline.sv
  - source/vic_sprite_dma.sv
  - source/vic_bus_arbiter.sv
  - source/vic_raster_irq.sv
  - source/vic_dma_core.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/tb_vic_dma_core.sv
